// ==== Bender.yml ====
package:
  name: exec_unit

sources:
  # packages first, then the datapath, then the top level.
  - files:
      - hdl/cpuTypesPkg.sv
      - hdl/aluOpsPkg.sv
      - hdl/alu.sv
      - hdl/registerFile.sv
      - hdl/instrDecoder.sv
      - hdl/execUnit.sv
  - target: simulation
    files:
      - verification/execUnitTb.sv

// ==== build.f ====
hdl/cpuTypesPkg.sv
hdl/aluOpsPkg.sv
hdl/alu.sv
hdl/registerFile.sv
hdl/instrDecoder.sv
hdl/execUnit.sv
verification/execUnitTb.sv

// ==== hdl/alu.sv ====
`timescale 1ns/1ps
// Registered ALU. Output and flags update one clock after the operands arrive.
// Flags keep their value unless the opcode defines them. Unused opcodes give 0.
module alu #(
	parameter int BITS = cpuTypesPkg::DATA_BITS
) (
	input  logic                  CLK,
	input  logic                  RSTb,
	input  cpuTypesPkg::dataWordT A,
	input  cpuTypesPkg::dataWordT B,
	input  aluOpsPkg::aluOpT      aluOp,
	output cpuTypesPkg::dataWordT aluOut,
	output logic                  C, // carry.
	output logic                  Z, // zero.
	output logic                  S  // sign.
);
	import cpuTypesPkg::*;
	import aluOpsPkg::*;

	logic            carryIn;
	logic            borrowIn;
	logic [BITS:0]   addRes; // top bit is carry out.
	logic [BITS:0]   subRes; // top bit is borrow out.
	logic [BITS-1:0] andRes;
	logic [BITS-1:0] orRes;
	logic [BITS-1:0] xorRes;
	logic [BITS-1:0] asrRes;
	logic [BITS-1:0] lsrRes;
	logic [BITS-1:0] lslRes;
	logic [BITS-1:0] rolcRes;
	logic [BITS-1:0] rorcRes;

	dataWordT outNext;
	logic     cNext;
	logic     zNext;
	logic     sNext;

	function automatic logic isZero(input logic [BITS-1:0] v);
		return (v == '0);
	endfunction

	// ====================
	// operation results
	// ====================
	assign carryIn  = (aluOp == OP_ADC) ? C : 1'b0;
	assign borrowIn = (aluOp == OP_SBB) ? C : 1'b0;

	assign addRes = {1'b0, A} + {1'b0, B} + {{BITS{1'b0}}, carryIn};
	assign subRes = {1'b0, A} - {1'b0, B} - {{BITS{1'b0}}, borrowIn};

	assign andRes = A & B;
	assign orRes  = A | B;
	assign xorRes = A ^ B;

	// single register shifts work on the source operand.
	assign asrRes  = {B[BITS-1], B[BITS-1:1]};
	assign lsrRes  = {1'b0, B[BITS-1:1]};
	assign lslRes  = {B[BITS-2:0], 1'b0};
	assign rolcRes = {B[BITS-2:0], C};
	assign rorcRes = {C, B[BITS-1:1]};

	// ====================
	// opcode select
	// ====================
	always_comb begin
		outNext = '0;
		cNext   = C;
		zNext   = Z;
		sNext   = S;
		case (aluOp)
			OP_MOV: outNext = B;
			OP_ADD, OP_ADC: begin
				outNext = addRes[BITS-1:0];
				cNext   = addRes[BITS];
				zNext   = isZero(addRes[BITS-1:0]);
				sNext   = addRes[BITS-1];
			end
			OP_SUB, OP_SBB: begin
				outNext = subRes[BITS-1:0];
				cNext   = subRes[BITS];
				zNext   = isZero(subRes[BITS-1:0]);
				sNext   = subRes[BITS-1];
			end
			OP_CMP: begin
				outNext = A; // destination untouched.
				cNext   = subRes[BITS];
				zNext   = isZero(subRes[BITS-1:0]);
				sNext   = subRes[BITS-1];
			end
			OP_AND: begin
				outNext = andRes;
				zNext   = isZero(andRes);
			end
			OP_OR: begin
				outNext = orRes;
				zNext   = isZero(orRes);
			end
			OP_XOR: begin
				outNext = xorRes;
				zNext   = isZero(xorRes);
			end
			OP_TEST: begin
				outNext = A;
				zNext   = isZero(andRes);
			end
			OP_ASR: begin
				outNext = asrRes;
				zNext   = isZero(asrRes);
			end
			OP_LSR: begin
				outNext = lsrRes;
				zNext   = isZero(lsrRes);
			end
			OP_LSL: begin
				outNext = lslRes;
				zNext   = isZero(lslRes);
			end
			OP_ROLC: begin
				outNext = rolcRes;
				cNext   = B[BITS-1]; // bit rotated out.
			end
			OP_RORC: begin
				outNext = rorcRes;
				cNext   = B[0];
			end
			OP_CLC: cNext = 1'b0;
			OP_STC: cNext = 1'b1;
			OP_CLZ: zNext = 1'b0;
			OP_STZ: zNext = 1'b1;
			OP_CLS: sNext = 1'b0;
			OP_STS: sNext = 1'b1;
			default: ; // mul, barrel and plain rotates, bit counts and reserved.
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			aluOut <= '0;
			C      <= 1'b0;
			Z      <= 1'b0;
			S      <= 1'b0;
		end else begin
			aluOut <= outNext;
			C      <= cNext;
			Z      <= zNext;
			S      <= sNext;
		end
	end

endmodule

// ==== hdl/aluOpsPkg.sv ====
// ALU opcode map. Codes missing from the enum are no-ops and never write back.
package aluOpsPkg;

	// ====================
	// opcodes
	// ====================
	typedef enum logic [cpuTypesPkg::OPC_BITS-1:0] {
		OP_MOV  = 5'd0,  // source to destination.
		OP_ADD  = 5'd1,
		OP_ADC  = 5'd2,  // add with carry in.
		OP_SUB  = 5'd3,
		OP_SBB  = 5'd4,  // subtract with borrow.
		OP_AND  = 5'd5,
		OP_OR   = 5'd6,
		OP_XOR  = 5'd7,
		// 8 to 11 held for mul and barrel shifts.
		OP_CMP  = 5'd12, // flags of a minus b.
		OP_TEST = 5'd13, // zero flag of a and b.
		OP_ASR  = 5'd16,
		OP_LSR  = 5'd17,
		OP_LSL  = 5'd18,
		OP_ROLC = 5'd19, // rotate left through carry.
		OP_RORC = 5'd20, // rotate right through carry.
		OP_CLC  = 5'd23,
		OP_STC  = 5'd24,
		OP_CLZ  = 5'd25,
		OP_STZ  = 5'd26,
		OP_CLS  = 5'd27,
		OP_STS  = 5'd28
	} aluOpT;

	// opcodes whose result lands in the destination register.
	function automatic logic opWritesBack(input aluOpT op);
		case (op)
			OP_MOV,
			OP_ADD,
			OP_ADC,
			OP_SUB,
			OP_SBB,
			OP_AND,
			OP_OR,
			OP_XOR,
			OP_ASR,
			OP_LSR,
			OP_LSL,
			OP_ROLC,
			OP_RORC: return 1'b1;
			default: return 1'b0; // compares, flag ops and unused codes.
		endcase
	endfunction

endpackage

// ==== hdl/cpuTypesPkg.sv ====
// Datapath widths and the instruction layout. Other data widths must be even and 8 or more.
// The instruction word stays 16 bits and its low three bits are ignored.
package cpuTypesPkg;

	// ====================
	// widths
	// ====================
	localparam int DATA_BITS    = 16; // register and alu word.
	localparam int REG_IDX_BITS = 4;  // sixteen registers.
	localparam int INSTR_BITS   = 16;
	localparam int OPC_BITS     = 5;  // opcode field.

	// ====================
	// instruction fields
	// ====================
	localparam int OPC_LSB = 11; // opcode in bits 15 to 11.
	localparam int RD_LSB  = 7;  // destination and operand a.
	localparam int RS_LSB  = 3;  // source and operand b.

	typedef logic [DATA_BITS-1:0]    dataWordT;
	typedef logic [REG_IDX_BITS-1:0] regIndexT;
	typedef logic [INSTR_BITS-1:0]   instrWordT;

endpackage

// ==== hdl/execUnit.sv ====
`timescale 1ns/1ps
// Execute slice top. Results show two clocks after the instruction strobe.
// Host loads are only safe while no instruction is in flight.
module execUnit #(
	parameter int BITS = cpuTypesPkg::DATA_BITS
) (
	input  logic                   CLK,
	input  logic                   RSTb,
	input  logic                   instrValid,
	input  cpuTypesPkg::instrWordT instr,
	input  logic                   loadEn,
	input  cpuTypesPkg::regIndexT  loadAddr,
	input  cpuTypesPkg::dataWordT  loadData,
	input  cpuTypesPkg::regIndexT  hostRdAddr,
	output cpuTypesPkg::dataWordT  hostRdData,
	output cpuTypesPkg::dataWordT  result,
	output logic                   resultValid,
	output logic                   C,
	output logic                   Z,
	output logic                   S
);
	import cpuTypesPkg::*;
	import aluOpsPkg::*;

	aluOpT    aluOp;
	regIndexT rdIdx;
	regIndexT rsIdx;
	dataWordT opA;
	dataWordT opB;
	logic     wbEn;
	regIndexT wbIdx;

	instrDecoder decoder (
		.CLK         (CLK),
		.RSTb        (RSTb),
		.instrValid  (instrValid),
		.instr       (instr),
		.aluOp       (aluOp),
		.rdIdx       (rdIdx),
		.rsIdx       (rsIdx),
		.wbEn        (wbEn),
		.wbIdx       (wbIdx),
		.resultValid (resultValid)
	);

	registerFile #(.BITS(BITS)) regFile (
		.CLK        (CLK),
		.rdIdx      (rdIdx),
		.rsIdx      (rsIdx),
		.opA        (opA),
		.opB        (opB),
		.wbEn       (wbEn),
		.wbIdx      (wbIdx),
		.wbData     (result), // alu output written back.
		.loadEn     (loadEn),
		.loadAddr   (loadAddr),
		.loadData   (loadData),
		.hostRdAddr (hostRdAddr),
		.hostRdData (hostRdData)
	);

	alu #(.BITS(BITS)) aluCore (
		.CLK    (CLK),
		.RSTb   (RSTb),
		.A      (opA),
		.B      (opB),
		.aluOp  (aluOp),
		.aluOut (result),
		.C      (C),
		.Z      (Z),
		.S      (S)
	);

endmodule

// ==== hdl/instrDecoder.sv ====
`timescale 1ns/1ps
// Two stage decoder. Stage one feeds the ALU and stage two lines write-back up with aluOut.
// Idle cycles present OP_MOV with nothing marked valid.
module instrDecoder (
	input  logic                   CLK,
	input  logic                   RSTb,
	input  logic                   instrValid,
	input  cpuTypesPkg::instrWordT instr,
	output aluOpsPkg::aluOpT       aluOp,
	output cpuTypesPkg::regIndexT  rdIdx,
	output cpuTypesPkg::regIndexT  rsIdx,
	output logic                   wbEn,
	output cpuTypesPkg::regIndexT  wbIdx,
	output logic                   resultValid
);
	import cpuTypesPkg::*;
	import aluOpsPkg::*;

	aluOpT    opField;
	regIndexT rdField;
	regIndexT rsField;
	logic     validS1;  // instruction now in the alu stage.
	logic     writesS1; // its result goes back.

	// field split.
	assign opField = aluOpT'(instr[OPC_LSB +: OPC_BITS]);
	assign rdField = instr[RD_LSB +: REG_IDX_BITS];
	assign rsField = instr[RS_LSB +: REG_IDX_BITS];

	// ====================
	// stage one
	// ====================
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			aluOp    <= OP_MOV;
			rdIdx    <= '0;
			rsIdx    <= '0;
			validS1  <= 1'b0;
			writesS1 <= 1'b0;
		end else begin
			validS1 <= instrValid;
			if (instrValid) begin
				aluOp    <= opField;
				rdIdx    <= rdField;
				rsIdx    <= rsField;
				writesS1 <= opWritesBack(opField);
			end else begin
				aluOp    <= OP_MOV; // leaves the flags alone.
				writesS1 <= 1'b0;
			end
		end
	end

	// ====================
	// stage two
	// ====================
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			resultValid <= 1'b0;
			wbEn        <= 1'b0;
		end else begin
			resultValid <= validS1;
			wbEn        <= writesS1; // already cleared on idle cycles.
		end
	end

	always_ff @(posedge CLK) begin
		wbIdx <= rdIdx;
	end

endmodule

// ==== hdl/registerFile.sv ====
`timescale 1ns/1ps
// Sixteen word register file. Write-back wins over a host load in the same cycle.
// Operand reads see the write-back data. The host read port shows stored contents only.
module registerFile #(
	parameter int BITS = cpuTypesPkg::DATA_BITS
) (
	input  logic                  CLK,
	input  cpuTypesPkg::regIndexT rdIdx,
	input  cpuTypesPkg::regIndexT rsIdx,
	output cpuTypesPkg::dataWordT opA,
	output cpuTypesPkg::dataWordT opB,
	input  logic                  wbEn,
	input  cpuTypesPkg::regIndexT wbIdx,
	input  cpuTypesPkg::dataWordT wbData,
	input  logic                  loadEn,
	input  cpuTypesPkg::regIndexT loadAddr,
	input  cpuTypesPkg::dataWordT loadData,
	input  cpuTypesPkg::regIndexT hostRdAddr,
	output cpuTypesPkg::dataWordT hostRdData
);
	import cpuTypesPkg::*;

	localparam int NUM_REGS = 2 ** REG_IDX_BITS;

	logic [BITS-1:0] regs [NUM_REGS];
	logic            hitA; // operand a is being written back.
	logic            hitB;

	// ====================
	// write port
	// ====================
	always_ff @(posedge CLK) begin
		if (wbEn) begin
			regs[wbIdx] <= wbData;
		end else if (loadEn) begin
			regs[loadAddr] <= loadData; // host preload.
		end
	end

	// ====================
	// read ports
	// ====================
	assign hitA = wbEn && (wbIdx == rdIdx);
	assign hitB = wbEn && (wbIdx == rsIdx);

	assign opA = hitA ? wbData : regs[rdIdx];
	assign opB = hitB ? wbData : regs[rsIdx];

	assign hostRdData = regs[hostRdAddr];

endmodule

// ==== verification/execUnitTb.sv ====
`timescale 1ns/1ps
// Directed tests of execUnit against a sequential model. Assumes the default 16-bit width.
// Host loads are issued only while the pipeline is idle.
module execUnitTb;
	import cpuTypesPkg::*;
	import aluOpsPkg::*;

	localparam int WAIT_LIMIT = 10; // cycles allowed for resultValid.
	localparam int CHAIN_LEN  = 48;

	logic      CLK = 1'b0;
	logic      RSTb;
	logic      instrValid;
	instrWordT instr;
	logic      loadEn;
	regIndexT  loadAddr;
	dataWordT  loadData;
	regIndexT  hostRdAddr;
	dataWordT  hostRdData;
	dataWordT  result;
	logic      resultValid;
	logic      C;
	logic      Z;
	logic      S;

	dataWordT    modelRegs [16];
	logic        mC = 1'b0; // model flags.
	logic        mZ = 1'b0;
	logic        mS = 1'b0;
	logic [31:0] lfsr = 32'h75336021;
	int          errCount = 0;
	int          checkCount = 0;

	execUnit #(.BITS(DATA_BITS)) UUT (
		.CLK(CLK), .RSTb(RSTb), .instrValid(instrValid), .instr(instr),
		.loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
		.hostRdAddr(hostRdAddr), .hostRdData(hostRdData), .result(result),
		.resultValid(resultValid), .C(C), .Z(Z), .S(S)
	);

	always #50 CLK = ~CLK;

	// ====================
	// helpers
	// ====================
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]}; // one lfsr step per bit.
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return v;
	endfunction

	task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		checkCount++;
		if (got !== exp) begin
			$display("MISMATCH %s got %0h expected %0h at %0t", name, got, exp, $time);
			errCount++;
		end
	endtask

	task automatic reportTest(input string name, input int startErr);
		$display("%-22s done, %0d errors", name, errCount - startErr);
	endtask

	task automatic loadReg(input regIndexT idx, input dataWordT val);
		@(posedge CLK);
		loadEn   <= 1'b1;
		loadAddr <= idx;
		loadData <= val;
		@(posedge CLK);
		loadEn <= 1'b0;
		modelRegs[idx] = val;
	endtask

	task automatic readReg(input regIndexT idx, output dataWordT val);
		@(posedge CLK);
		hostRdAddr <= idx;
		@(negedge CLK);
		val = hostRdData; // combinational port, stable at the falling edge.
	endtask

	task automatic checkAllRegs();
		dataWordT got;
		for (int i = 0; i < 16; i++) begin
			readReg(i, got);
			checkEq("hostRdData", got, modelRegs[i]);
		end
	endtask

	task automatic waitResult(output bit ok, output int cycles);
		cycles = 0;
		ok = 1'b0;
		while (!ok && cycles < WAIT_LIMIT) begin
			@(negedge CLK);
			ok = resultValid;
			cycles++;
		end
		if (!ok) begin
			$display("timeout: resultValid did not rise within %0d cycles", WAIT_LIMIT);
			errCount++;
		end
	endtask

	// ====================
	// reference model
	// ====================
	task automatic modelExec(input logic [4:0] op, input regIndexT rd, input regIndexT rs,
			output dataWordT out);
		dataWordT           a;
		dataWordT           b;
		logic [DATA_BITS:0] wide;
		a = modelRegs[rd];
		b = modelRegs[rs];
		out = '0;
		wide = '0;
		if (op == OP_ADD || op == OP_ADC) begin
			wide = {1'b0, a} + b + ((op == OP_ADC) && mC);
		end else if (op == OP_SUB || op == OP_SBB || op == OP_CMP) begin
			wide = {1'b0, a} - b - ((op == OP_SBB) && mC); // top bit is the borrow.
		end
		case (op)
			OP_MOV: out = b;
			OP_ADD, OP_ADC, OP_SUB, OP_SBB, OP_CMP: begin
				out = (op == OP_CMP) ? a : wide[DATA_BITS-1:0];
				mC  = wide[DATA_BITS];
				mZ  = (wide[DATA_BITS-1:0] == 0);
				mS  = wide[DATA_BITS-1];
			end
			OP_AND: out = a & b;
			OP_OR: out = a | b;
			OP_XOR: out = a ^ b;
			OP_TEST: out = a;
			OP_ASR: out = $signed(b) >>> 1;
			OP_LSR: out = b >> 1;
			OP_LSL: out = b << 1;
			OP_ROLC: begin
				out = {b[DATA_BITS-2:0], mC};
				mC  = b[DATA_BITS-1];
			end
			OP_RORC: begin
				out = {mC, b[DATA_BITS-1:1]};
				mC  = b[0];
			end
			OP_CLC: mC = 1'b0;
			OP_STC: mC = 1'b1;
			OP_CLZ: mZ = 1'b0;
			OP_STZ: mZ = 1'b1;
			OP_CLS: mS = 1'b0;
			OP_STS: mS = 1'b1;
			default: ; // unused codes give 0.
		endcase
		case (op)
			OP_AND, OP_OR, OP_XOR, OP_ASR, OP_LSR, OP_LSL: mZ = (out == 0);
			OP_TEST: mZ = ((a & b) == 0);
			default: ;
		endcase
		case (op)
			OP_MOV, OP_ADD, OP_ADC, OP_SUB, OP_SBB, OP_AND, OP_OR, OP_XOR,
			OP_ASR, OP_LSR, OP_LSL, OP_ROLC, OP_RORC: modelRegs[rd] = out;
			default: ;
		endcase
	endtask

	// one instruction, then result, flags and destination.
	task automatic runOp(input logic [4:0] op, input regIndexT rd, input regIndexT rs);
		dataWordT expOut;
		dataWordT got;
		bit       ok;
		int       lat;
		modelExec(op, rd, rs, expOut);
		@(posedge CLK);
		instrValid <= 1'b1;
		instr      <= {op, rd, rs, 3'(randBits(3))}; // low bits are don't care.
		@(posedge CLK);
		instrValid <= 1'b0;
		waitResult(ok, lat);
		if (ok) begin
			checkEq("resultValid latency", lat, 2);
			checkEq("result", result, expOut);
			checkEq("C", C, mC);
			checkEq("Z", Z, mZ);
			checkEq("S", S, mS);
		end
		readReg(rd, got);
		checkEq("hostRdData", got, modelRegs[rd]);
		checkEq("resultValid", resultValid, 0); // one cycle pulse.
	endtask

	task automatic randomFlags();
		runOp(randBits(1) ? OP_STC : OP_CLC, 0, 0);
		runOp(randBits(1) ? OP_STZ : OP_CLZ, 0, 0);
		runOp(randBits(1) ? OP_STS : OP_CLS, 0, 0);
	endtask

	task automatic presetFlags(input logic v);
		runOp(v ? OP_STC : OP_CLC, 0, 0);
		runOp(v ? OP_STZ : OP_CLZ, 0, 0);
		runOp(v ? OP_STS : OP_CLS, 0, 0);
	endtask

	// ====================
	// directed tests
	// ====================
	task automatic testResetHost();
		int startErr;
		startErr = errCount;
		@(negedge CLK);
		checkEq("resultValid", resultValid, 0);
		checkEq("result", result, 0);
		checkEq("C", C, 0);
		checkEq("Z", Z, 0);
		checkEq("S", S, 0);
		for (int i = 0; i < 16; i++) begin
			loadReg(i, randBits(DATA_BITS));
		end
		checkAllRegs();
		reportTest("reset and host port", startErr);
	endtask

	task automatic testArithmetic();
		int         startErr;
		dataWordT   edgeVals [5] = '{16'h0000, 16'hFFFF, 16'h7FFF, 16'h8000, 16'h0001};
		logic [4:0] ops [5] = '{OP_ADD, OP_ADC, OP_SUB, OP_SBB, OP_CMP};
		startErr = errCount;
		foreach (ops[k]) begin
			foreach (edgeVals[i]) begin
				foreach (edgeVals[j]) begin
					loadReg(1, edgeVals[i]);
					loadReg(2, edgeVals[j]);
					runOp(ops[k], 1, 2);
				end
			end
			for (int n = 0; n < 10; n++) begin
				runOp(ops[k], randBits(4), randBits(4)); // random register contents.
			end
		end
		reportTest("arithmetic", startErr);
	endtask

	task automatic testLogicShift();
		int         startErr;
		logic [4:0] ops [10] = '{OP_AND, OP_OR, OP_XOR, OP_TEST, OP_ASR,
			OP_LSR, OP_LSL, OP_ROLC, OP_RORC, OP_MOV};
		startErr = errCount;
		foreach (ops[k]) begin
			for (int n = 0; n < 8; n++) begin
				randomFlags(); // so that untouched flags are visible.
				loadReg(1, randBits(DATA_BITS));
				loadReg(2, (n == 0) ? '0 : randBits(DATA_BITS));
				runOp(ops[k], 1, 2);
			end
		end
		reportTest("logic and shifts", startErr);
	endtask

	task automatic testFlagsReserved();
		int         startErr;
		logic [4:0] flagOps [6] = '{OP_CLC, OP_STC, OP_CLZ, OP_STZ, OP_CLS, OP_STS};
		logic [4:0] reserved [11] = '{8, 9, 10, 11, 14, 15, 21, 22, 29, 30, 31};
		startErr = errCount;
		for (int pass = 0; pass < 2; pass++) begin
			foreach (flagOps[i]) begin
				presetFlags(pass == 1); // all clear first, then all set.
				runOp(flagOps[i], 0, 0);
			end
		end
		foreach (reserved[i]) begin
			randomFlags();
			runOp(reserved[i], randBits(4), randBits(4)); // pulses resultValid, no write.
			checkAllRegs();
		end
		reportTest("flags and reserved", startErr);
	endtask

	task automatic testChain();
		int         startErr;
		instrWordT  words [CHAIN_LEN];
		dataWordT   expOut [CHAIN_LEN];
		logic [2:0] expFlags [CHAIN_LEN];
		logic [4:0] op;
		regIndexT   rd;
		regIndexT   rs;
		bit         ok;
		int         lat;
		startErr = errCount;
		for (int i = 0; i < CHAIN_LEN; i++) begin
			op = randBits(5);
			rd = randBits(2); // four registers keep the chain dependent.
			rs = randBits(2);
			modelExec(op, rd, rs, expOut[i]);
			expFlags[i] = {mC, mZ, mS};
			words[i] = {op, rd, rs, 3'b000};
		end
		fork
			begin
				for (int i = 0; i < CHAIN_LEN; i++) begin
					@(posedge CLK);
					instrValid <= 1'b1;
					instr      <= words[i];
				end
				@(posedge CLK);
				instrValid <= 1'b0;
			end
			begin
				for (int i = 0; i < CHAIN_LEN; i++) begin
					waitResult(ok, lat);
					if (!ok) break;
					if (i > 0) begin
						checkEq("resultValid latency", lat, 1); // one result per cycle.
					end
					checkEq("result", result, expOut[i]);
					checkEq("C", C, expFlags[i][2]);
					checkEq("Z", Z, expFlags[i][1]);
					checkEq("S", S, expFlags[i][0]);
				end
			end
		join
		checkAllRegs();
		reportTest("back-to-back chain", startErr);
	endtask

	// ====================
	// main sequence
	// ====================
	initial begin
		RSTb       = 1'b0;
		instrValid = 1'b0;
		instr      = '0;
		loadEn     = 1'b0;
		loadAddr   = '0;
		loadData   = '0;
		hostRdAddr = '0;
		repeat (2) @(posedge CLK);
		RSTb <= 1'b1;
		testResetHost();
		testArithmetic();
		testLogicShift();
		testFlagsReserved();
		testChain();
		$display("%0d checks, %0d errors", checkCount, errCount);
		if (errCount == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
